// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_alu.sv
      - hdl/rv_regfile.sv
      - hdl/rv_decode.sv
      - hdl/rv_control_fsm.sv
      - hdl/rv_datapath.sv
      - hdl/rv_core_top.sv
  - target: test
    files:
      - tb/tb_rv_core.sv

// File: hdl/rv_alu.sv
// ------------------------------
// Integer ALU.
// Ten RV64I operations plus compare flags.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_core_pkg::alu_op_e                 i_op,
    input  wire logic [rv_core_pkg::XLEN-1:0]    i_a,
    input  wire logic [rv_core_pkg::XLEN-1:0]    i_b,
    output logic      [rv_core_pkg::XLEN-1:0]    o_y,
    output rv_core_pkg::alu_flags_t              o_flags
);
    import rv_core_pkg::*;

    logic [XLEN:0]   diff;
    logic [5:0]      shamt;

    // Extra bit holds the borrow.
    assign diff  = {1'b0, i_a} - {1'b0, i_b};
    assign shamt = i_b[5:0];

    assign o_flags.zero = (diff[XLEN-1:0] == '0);
    assign o_flags.ltu  = diff[XLEN];
    // Signs differ, so a negative a is the smaller one.
    assign o_flags.lt   = (i_a[XLEN-1] ^ i_b[XLEN-1]) ? i_a[XLEN-1] : diff[XLEN-1];

    always_comb begin
        case (i_op)
            ALU_ADD:  o_y = i_a + i_b;
            ALU_SUB:  o_y = diff[XLEN-1:0];
            ALU_AND:  o_y = i_a & i_b;
            ALU_OR:   o_y = i_a | i_b;
            ALU_XOR:  o_y = i_a ^ i_b;
            ALU_SLL:  o_y = i_a << shamt;
            ALU_SRL:  o_y = i_a >> shamt;
            ALU_SRA:  o_y = $signed(i_a) >>> shamt;
            ALU_SLT:  o_y = {{(XLEN-1){1'b0}}, o_flags.lt};
            ALU_SLTU: o_y = {{(XLEN-1){1'b0}}, o_flags.ltu};
            default:  o_y = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_control_fsm.sv
// ------------------------------
// Multicycle control FSM.
// Steps fetch, decode, execute and
// writeback and drives the control word.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_control_fsm (
    input  wire logic                clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_instr_valid,
    input  rv_core_pkg::decode_t     i_dec,
    input  wire logic                i_illegal,
    input  rv_core_pkg::alu_flags_t  i_flags,
    output logic                     o_fetch,
    output rv_core_pkg::ctrl_t       o_ctrl
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {S_FETCH, S_DECODE, S_EXECUTE, S_WRITEBACK} state_e;

    state_e state_q;
    state_e state_d;
    logic   armed_q;
    logic   fetch_q;
    logic   taken;

    // ------------------------------
    // State register and fetch strobe.
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= S_FETCH;
            armed_q <= 1'b0;
            fetch_q <= 1'b0;
        end else begin
            state_q <= state_d;
            armed_q <= 1'b1;
            // Pulse once on entry to fetch, and once out of reset.
            fetch_q <= (state_d == S_FETCH) && ((state_q != S_FETCH) || !armed_q);
        end
    end

    assign o_fetch = fetch_q;

    always_comb begin
        case (state_q)
            S_FETCH:     state_d = i_instr_valid ? S_DECODE : S_FETCH;
            S_DECODE:    state_d = S_EXECUTE;
            S_EXECUTE:   state_d = S_WRITEBACK;
            default:     state_d = S_FETCH;
        endcase
    end

    // Branch condition from funct3.
    always_comb begin
        case (i_dec.br_cond)
            3'b000:  taken = i_flags.zero;
            3'b001:  taken = !i_flags.zero;
            3'b100:  taken = i_flags.lt;
            3'b101:  taken = !i_flags.lt;
            3'b110:  taken = i_flags.ltu;
            3'b111:  taken = !i_flags.ltu;
            default: taken = 1'b0;
        endcase
    end

    // ------------------------------
    // Control word per step.
    // ------------------------------
    always_comb begin
        o_ctrl         = '0;
        o_ctrl.src_a   = SRC_A_PC;
        o_ctrl.src_b   = SRC_B_FOUR;
        o_ctrl.res_sel = RES_ALU;
        o_ctrl.alu_op  = ALU_ADD;
        case (state_q)
            S_FETCH: begin
                // PC plus four through the ALU.
                o_ctrl.ir_en     = i_instr_valid;
                o_ctrl.old_pc_en = i_instr_valid;
                o_ctrl.pc_en     = i_instr_valid;
            end
            S_DECODE: begin
                o_ctrl.opnd_en = 1'b1;
                o_ctrl.res_en  = 1'b1;
                o_ctrl.src_a   = SRC_A_OLD_PC;
                o_ctrl.src_b   = SRC_B_IMM;
            end
            S_EXECUTE: begin
                o_ctrl.src_a   = SRC_A_REG;
                o_ctrl.src_b   = SRC_B_REG;
                o_ctrl.res_sel = RES_ALU_REG;
                if (!i_illegal) begin
                    case (i_dec.cls)
                        OPC_OP: begin
                            o_ctrl.alu_op = i_dec.alu_op;
                            o_ctrl.res_en = 1'b1;
                        end
                        OPC_OP_IMM: begin
                            o_ctrl.src_b  = SRC_B_IMM;
                            o_ctrl.alu_op = i_dec.alu_op;
                            o_ctrl.res_en = 1'b1;
                        end
                        OPC_BRANCH: begin
                            o_ctrl.alu_op = ALU_SUB;
                            o_ctrl.pc_en  = taken;
                        end
                        OPC_JAL: o_ctrl.pc_en = 1'b1;
                        default: o_ctrl.pc_en = 1'b0;
                    endcase
                end
            end
            default: begin
                o_ctrl.retire  = 1'b1;
                o_ctrl.rf_we   = i_dec.we;
                o_ctrl.res_sel = RES_ALU_REG;
                if (i_dec.cls == OPC_LUI) begin
                    o_ctrl.res_sel = RES_IMM;
                end else if (i_dec.cls == OPC_JAL) begin
                    // Link value is old PC plus four.
                    o_ctrl.res_sel = RES_ALU;
                    o_ctrl.src_a   = SRC_A_OLD_PC;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_core_pkg.sv
// ------------------------------
// RV64I multicycle core package.
// Widths, opcode and ALU encodings,
// decode and control words, retire record.
// ------------------------------
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes kept in this core.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {IMM_I, IMM_U, IMM_B, IMM_J} imm_sel_e;

    // ------------------------------
    // Datapath mux selects.
    // ------------------------------
    typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_REG} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [1:0] {RES_ALU_REG, RES_ALU, RES_IMM} result_src_e;

    typedef struct packed {
        opcode_e                cls;
        alu_op_e                alu_op;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        imm;
        logic [2:0]             br_cond;
        logic                   we;
    } decode_t;

    typedef struct packed {
        logic        ir_en;
        logic        pc_en;
        logic        old_pc_en;
        logic        opnd_en;
        logic        res_en;
        logic        rf_we;
        src_a_e      src_a;
        src_b_e      src_b;
        result_src_e res_sel;
        alu_op_e     alu_op;
        logic        retire;
    } ctrl_t;

    typedef struct packed {
        logic zero;
        logic lt;
        logic ltu;
    } alu_flags_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/rv_core_top.sv
// ------------------------------
// RV64I multicycle core top level.
// Joins decoder, control FSM and datapath.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic [rv_core_pkg::ILEN-1:0]  i_instr,
    input  wire logic                          i_instr_valid,
    output logic                               o_fetch,
    output logic      [rv_core_pkg::XLEN-1:0]  o_pc,
    output rv_core_pkg::retire_t               o_retire
);
    import rv_core_pkg::*;

    logic [ILEN-1:0] ir;
    decode_t         dec;
    logic            illegal;
    ctrl_t           ctrl;
    alu_flags_t      flags;

    rv_decode u_decode (
        .i_instr   ( ir      ),
        .o_dec     ( dec     ),
        .o_illegal ( illegal )
    );

    rv_control_fsm u_control (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_instr_valid ( i_instr_valid ),
        .i_dec         ( dec           ),
        .i_illegal     ( illegal       ),
        .i_flags       ( flags         ),
        .o_fetch       ( o_fetch       ),
        .o_ctrl        ( ctrl          )
    );

    rv_datapath #(
        .RESET_PC ( RESET_PC )
    ) u_datapath (
        .clk      ( clk      ),
        .i_rst_n  ( i_rst_n  ),
        .i_instr  ( i_instr  ),
        .i_dec    ( dec      ),
        .i_ctrl   ( ctrl     ),
        .o_ir     ( ir       ),
        .o_pc     ( o_pc     ),
        .o_flags  ( flags    ),
        .o_retire ( o_retire )
    );

endmodule

`default_nettype wire

// File: hdl/rv_datapath.sv
// ------------------------------
// Multicycle datapath.
// PC, IR, operand and result registers,
// the ALU, the register file and muxes.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_datapath #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire logic                          clk,
    input  wire logic                          i_rst_n,
    input  wire logic [rv_core_pkg::ILEN-1:0]  i_instr,
    input  rv_core_pkg::decode_t               i_dec,
    input  rv_core_pkg::ctrl_t                 i_ctrl,
    output logic      [rv_core_pkg::ILEN-1:0]  o_ir,
    output logic      [rv_core_pkg::XLEN-1:0]  o_pc,
    output rv_core_pkg::alu_flags_t            o_flags,
    output rv_core_pkg::retire_t               o_retire
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] pc_q, old_pc_q, a_q, b_q, res_q;
    logic [ILEN-1:0] ir_q;
    logic [XLEN-1:0] rdata1, rdata2;
    logic [XLEN-1:0] alu_a, alu_b, alu_y, result;

    // ------------------------------
    // Nonarchitectural registers.
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_q     <= RESET_PC;
            old_pc_q <= '0;
            ir_q     <= '0;
            a_q      <= '0;
            b_q      <= '0;
            res_q    <= '0;
        end else begin
            if (i_ctrl.pc_en)     pc_q     <= result;
            if (i_ctrl.old_pc_en) old_pc_q <= pc_q;
            if (i_ctrl.ir_en)     ir_q     <= i_instr;
            if (i_ctrl.opnd_en) begin
                a_q <= rdata1;
                b_q <= rdata2;
            end
            if (i_ctrl.res_en)    res_q    <= alu_y;
        end
    end

    always_comb begin
        case (i_ctrl.src_a)
            SRC_A_OLD_PC: alu_a = old_pc_q;
            SRC_A_REG:    alu_a = a_q;
            default:      alu_a = pc_q;
        endcase
        case (i_ctrl.src_b)
            SRC_B_REG:    alu_b = b_q;
            SRC_B_IMM:    alu_b = i_dec.imm;
            default:      alu_b = XLEN'(4);
        endcase
        // Feeds both the PC and the register file.
        case (i_ctrl.res_sel)
            RES_ALU:      result = alu_y;
            RES_IMM:      result = i_dec.imm;
            default:      result = res_q;
        endcase
    end

    rv_alu u_alu (
        .i_op    ( i_ctrl.alu_op ),
        .i_a     ( alu_a         ),
        .i_b     ( alu_b         ),
        .o_y     ( alu_y         ),
        .o_flags ( o_flags       )
    );

    rv_regfile u_regfile (
        .clk      ( clk          ),
        .i_rst_n  ( i_rst_n      ),
        .i_rs1    ( i_dec.rs1    ),
        .i_rs2    ( i_dec.rs2    ),
        .i_rd     ( i_dec.rd     ),
        .i_we     ( i_ctrl.rf_we ),
        .i_wdata  ( result       ),
        .o_rdata1 ( rdata1       ),
        .o_rdata2 ( rdata2       )
    );

    assign o_ir = ir_q;
    assign o_pc = pc_q;

    assign o_retire.valid = i_ctrl.retire;
    assign o_retire.pc    = old_pc_q;
    assign o_retire.rd    = i_dec.rd;
    assign o_retire.we    = i_ctrl.rf_we;
    assign o_retire.data  = result;

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
// ------------------------------
// Instruction decoder.
// Splits the instruction register, picks
// class and ALU op, extends the immediate.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire logic [rv_core_pkg::ILEN-1:0] i_instr,
    output rv_core_pkg::decode_t              o_dec,
    output logic                              o_illegal
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_sel_e   imm_sel;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    always_comb begin
        o_dec.cls     = opcode_e'(opcode);
        o_dec.alu_op  = ALU_ADD;
        o_dec.rs1     = i_instr[19:15];
        o_dec.rs2     = i_instr[24:20];
        o_dec.rd      = i_instr[11:7];
        o_dec.br_cond = funct3;
        o_dec.we      = 1'b1;
        o_illegal     = 1'b0;
        imm_sel       = IMM_I;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: o_dec.alu_op = ALU_ADD;
                    10'b0100000_000: o_dec.alu_op = ALU_SUB;
                    10'b0000000_001: o_dec.alu_op = ALU_SLL;
                    10'b0000000_010: o_dec.alu_op = ALU_SLT;
                    10'b0000000_011: o_dec.alu_op = ALU_SLTU;
                    10'b0000000_100: o_dec.alu_op = ALU_XOR;
                    10'b0000000_101: o_dec.alu_op = ALU_SRL;
                    10'b0100000_101: o_dec.alu_op = ALU_SRA;
                    10'b0000000_110: o_dec.alu_op = ALU_OR;
                    10'b0000000_111: o_dec.alu_op = ALU_AND;
                    default:         o_illegal    = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: o_dec.alu_op = ALU_ADD;
                    3'b010: o_dec.alu_op = ALU_SLT;
                    3'b011: o_dec.alu_op = ALU_SLTU;
                    3'b100: o_dec.alu_op = ALU_XOR;
                    3'b110: o_dec.alu_op = ALU_OR;
                    3'b111: o_dec.alu_op = ALU_AND;
                    3'b001: begin
                        o_dec.alu_op = ALU_SLL;
                        o_illegal    = (i_instr[31:26] != 6'b000000);
                    end
                    default: begin
                        // Bit 30 separates srai from srli.
                        o_dec.alu_op = i_instr[30] ? ALU_SRA : ALU_SRL;
                        o_illegal    = ({i_instr[31], i_instr[29:26]} != 5'b00000);
                    end
                endcase
            end
            OPC_LUI, OPC_AUIPC: imm_sel = IMM_U;
            OPC_JAL:            imm_sel = IMM_J;
            OPC_BRANCH: begin
                imm_sel   = IMM_B;
                o_dec.we  = 1'b0;
                o_illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            default: o_illegal = 1'b1;
        endcase
        if (o_illegal) begin
            o_dec.we = 1'b0;
        end
    end

    // Sign extension per format.
    always_comb begin
        case (imm_sel)
            IMM_U: o_dec.imm = {{(XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
            IMM_B: o_dec.imm = {{(XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                                i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_J: o_dec.imm = {{(XLEN-21){i_instr[31]}}, i_instr[31], i_instr[19:12],
                                i_instr[20], i_instr[30:21], 1'b0};
            default: o_dec.imm = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
// ------------------------------
// Register file, 32 x XLEN.
// Two read ports, one write port, x0 is zero.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic                                clk,
    input  wire logic                                i_rst_n,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  i_rs1,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  i_rs2,
    input  wire logic [rv_core_pkg::REG_ADDR_W-1:0]  i_rd,
    input  wire logic                                i_we,
    input  wire logic [rv_core_pkg::XLEN-1:0]        i_wdata,
    output logic      [rv_core_pkg::XLEN-1:0]        o_rdata1,
    output logic      [rv_core_pkg::XLEN-1:0]        o_rdata2
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: tb/tb_rv_core.sv
// ------------------------------
// Testbench for the RV64I multicycle core.
// Random legal instructions, a reference
// model, and retire and fetch checks.
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 64'h0;
    localparam int N_INSTR        = 300;
    // Up to 8 cycles per instruction, plus reset and margin.
    localparam int TIMEOUT_CYCLES = 3000;

    logic            clk;
    logic            i_rst_n;
    logic [ILEN-1:0] i_instr;
    logic            i_instr_valid;
    logic            o_fetch;
    logic [XLEN-1:0] o_pc;
    retire_t         o_retire;

    integer          seed = 79;
    int              cycle = 0;
    int              since_rel = 0;
    int              fetches = 0;
    int              retired = 0;
    int              retire_due = 0;
    int              last_retire = 0;
    int              value_errs = 0;
    int              protocol_errs = 0;
    logic [XLEN-1:0] model_x [32];
    logic [XLEN-1:0] model_pc = RESET_PC;
    logic [31:0]     pending [$];

    rv_core_top #(
        .RESET_PC ( RESET_PC )
    ) i_dut (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_instr       ( i_instr       ),
        .i_instr_valid ( i_instr_valid ),
        .o_fetch       ( o_fetch       ),
        .o_pc          ( o_pc          ),
        .o_retire      ( o_retire      )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // ------------------------------
    // Random legal instruction.
    // ------------------------------
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [12:0] boff;
        logic [20:0] joff;
        int          kind;
        // Eight registers keep values flowing between instructions.
        rd   = 5'(rand_below(8));
        rs1  = 5'(rand_below(8));
        rs2  = (rand_below(4) == 0) ? rs1 : 5'(rand_below(8));
        f3   = 3'(rand_below(8));
        alt  = 1'(rand_below(2));
        kind = rand_below(16);
        if (kind < 5) begin
            alt = alt && (f3 == 3'd0 || f3 == 3'd5);
            return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind < 10) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                alt = alt && (f3 == 3'd5);
                return {1'b0, alt, 4'b0, 6'(rand_below(64)), rs1, f3, rd, 7'b0010011};
            end
            return {12'($random(seed)), rs1, f3, rd, 7'b0010011};
        end else if (kind == 10) begin
            return {20'($random(seed)), rd, 7'b0110111};
        end else if (kind == 11) begin
            return {20'($random(seed)), rd, 7'b0010111};
        end else if (kind == 12) begin
            joff = 21'((rand_below(33) - 16) * 4);
            return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        end
        // Codes 2 and 3 are not branches and fold onto blt and bge.
        if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = f3 ^ 3'b110;
        end
        boff = 13'((rand_below(17) - 8) * 4);
        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
    endfunction

    // ------------------------------
    // Reference model.
    // ------------------------------
    function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return (sa < sb) ? 64'd1 : 64'd0;
            3'd3:    return (a < b) ? 64'd1 : 64'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 64'(sa >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
                                          input logic [63:0] a, input logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return sa < sb;
            3'd5:    return sa >= sb;
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic retire_t model_exec(input logic [31:0] instr, input logic [63:0] pc,
                                           output logic [63:0] next_pc);
        retire_t     r;
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic [63:0] imm_b;
        logic [63:0] imm_j;
        f3    = instr[14:12];
        a     = model_x[instr[19:15]];
        b     = model_x[instr[24:20]];
        imm_i = {{52{instr[31]}}, instr[31:20]};
        imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
        imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.rd    = instr[11:7];
        r.we    = 1'b1;
        next_pc = pc + 64'd4;
        case (instr[6:0])
            7'b0110011: r.data = ref_alu(f3, instr[30], a, b);
            // Bit 30 is an immediate bit except for srai.
            7'b0010011: r.data = ref_alu(f3, instr[30] && (f3 == 3'd5), a, imm_i);
            7'b0110111: r.data = imm_u;
            7'b0010111: r.data = pc + imm_u;
            7'b1101111: begin
                r.data  = pc + 64'd4;
                next_pc = pc + imm_j;
            end
            default: begin
                r.we = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    next_pc = pc + imm_b;
                end
            end
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expv,
                               input logic [63:0] actv);
        assert (expv === actv) else begin
            $display("ERR %s instr %0d expected %h actual %h", name, retired, expv, actv);
            value_errs++;
        end
    endtask

    // ------------------------------
    // Compare process.
    // ------------------------------
    always @(posedge clk) begin : compare
        retire_t     expect_r;
        logic [63:0] next_pc;
        cycle++;
        if (!i_rst_n) begin
            // Outputs are known once the first reset edge has passed.
            if (cycle > 1) begin
                assert (!o_fetch && !o_retire.valid) else begin
                    $display("core issued a fetch or retire while reset was held");
                    protocol_errs++;
                end
                check_value("reset_pc", RESET_PC, o_pc);
            end
        end else begin
            since_rel++;
            if (i_instr_valid) begin
                pending.push_back(i_instr);
                retire_due = cycle + 3;
            end
            if (o_fetch) begin
                if (fetches == 0) begin
                    check_value("first_fetch_cycle", 64'd2, 64'(since_rel));
                end else begin
                    check_value("fetch_after_retire", 64'(last_retire + 1), 64'(cycle));
                end
                check_value("fetch_pc", model_pc, o_pc);
                fetches++;
            end
            if (o_retire.valid) begin
                check_value("retire_cycle", 64'(retire_due), 64'(cycle));
                assert (pending.size() != 0) else begin
                    $display("retire pulse came with no instruction outstanding");
                    protocol_errs++;
                end
                if (pending.size() != 0) begin
                    expect_r = model_exec(pending.pop_front(), model_pc, next_pc);
                    check_value("retire_pc", expect_r.pc, o_retire.pc);
                    check_value("retire_we", 64'(expect_r.we), 64'(o_retire.we));
                    if (expect_r.we) begin
                        check_value("retire_rd", 64'(expect_r.rd), 64'(o_retire.rd));
                        check_value("retire_data", expect_r.data, o_retire.data);
                        if (expect_r.rd != 5'd0) begin
                            model_x[expect_r.rd] = expect_r.data;
                        end
                    end
                    model_pc    = next_pc;
                    last_retire = cycle;
                    retired++;
                end
            end
        end
    end

    // ------------------------------
    // Stimulus and end of run.
    // ------------------------------
    initial begin
        for (int i = 0; i < 32; i++) begin
            model_x[i] = '0;
        end
        i_rst_n       = 1'b0;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            do @(posedge clk); while (!o_fetch);
            repeat (rand_below(4)) @(posedge clk);
            i_instr       <= random_instr();
            i_instr_valid <= 1'b1;
            @(posedge clk);
            i_instr_valid <= 1'b0;
        end
        wait (retired == N_INSTR);
        repeat (2) @(posedge clk);
        $display("Checks done: %0d retired, %0d value errors, %0d protocol errors",
                 retired, value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                 cycle, retired, N_INSTR);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/rv_core_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_control_fsm.sv
hdl/rv_datapath.sv
hdl/rv_core_top.sv
tb/tb_rv_core.sv
